// ==== hssl_reg_bank.f ====
+incdir+.
hssl_reg_pkg.sv
hssl_access_decoder.sv
hssl_config_regs.sv
hssl_diag_counters.sv
hssl_read_mux.sv
hssl_reg_bank.sv
tb_hssl_reg_bank.sv

// ==== tb_hssl_reg_model.svh ====
/*
  register model for the hssl register bank testbench
  shadow copies of cfg, rt, ctr and read data, plus typed compare tasks
*/
`ifndef TB_HSSL_REG_MODEL_SVH
`define TB_HSSL_REG_MODEL_SVH

  hssl_reg_pkg::cfg_t     m_cfg;
  hssl_reg_pkg::rt_tab_t  m_rt;
  hssl_reg_pkg::ctr_arr_t m_ctr;
  hssl_reg_pkg::word_t    m_prdata;
  logic                   m_ready;
  int                     err_total;
  int                     err_test;

  // --------------------------------------------------------------------------
  // model state updates
  // --------------------------------------------------------------------------
  task automatic model_defaults();
    m_cfg.stop      = hssl_reg_pkg::STOP_DEF[0];
    m_cfg.reply_key = hssl_reg_pkg::REPLY_KEY_DEF;
    m_cfg.in_wait   = hssl_reg_pkg::IN_WAIT_DEF;
    m_cfg.out_wait  = hssl_reg_pkg::OUT_WAIT_DEF;
    m_cfg.out_tick  = hssl_reg_pkg::OUT_TICK_DEF;
    m_cfg.out_size  = hssl_reg_pkg::OUT_SIZE_DEF[9:0];
    for (int r = 0; r < hssl_reg_pkg::NUM_RTREGS; r++)
    begin
      m_rt.key[r]   = hssl_reg_pkg::RT_KEY_DEF;
      m_rt.mask[r]  = hssl_reg_pkg::RT_MSK_DEF;
      m_rt.route[r] = hssl_reg_pkg::RT_RTE_DEF[2:0];
    end
  endtask

  // granted write, soft reset leaves the counters alone
  task automatic model_write(input hssl_reg_pkg::sec_t s, input hssl_reg_pkg::idx_t i,
                             input hssl_reg_pkg::word_t d);
    if (s == hssl_reg_pkg::SEC_IFCAS)
    begin
      case (i)
        hssl_reg_pkg::REG_STOP:      m_cfg.stop = d[0];
        hssl_reg_pkg::REG_SOFT_RES:  model_defaults();
        hssl_reg_pkg::REG_REPLY_KEY: m_cfg.reply_key = d;
        hssl_reg_pkg::REG_IN_WAIT:   m_cfg.in_wait = d;
        hssl_reg_pkg::REG_OUT_WAIT:  m_cfg.out_wait = d;
        hssl_reg_pkg::REG_OUT_TICK:  m_cfg.out_tick = d;
        hssl_reg_pkg::REG_OUT_SIZE:  m_cfg.out_size = d[9:0];
        default: ;
      endcase
    end
    else if (s == hssl_reg_pkg::SEC_RTKEY && i < hssl_reg_pkg::NUM_RTREGS)
      m_rt.key[i] = d;
    else if (s == hssl_reg_pkg::SEC_RTMSK && i < hssl_reg_pkg::NUM_RTREGS)
      m_rt.mask[i] = d;
    else if (s == hssl_reg_pkg::SEC_RTRTE && i < hssl_reg_pkg::NUM_RTREGS)
      m_rt.route[i] = d[2:0];
    else if (s == hssl_reg_pkg::SEC_DCCNT && i < hssl_reg_pkg::NUM_DCREGS)
      m_ctr[i] = d;
  endtask

  task automatic model_count(input logic [hssl_reg_pkg::NUM_DCREGS-1:0] en);
    for (int c = 0; c < hssl_reg_pkg::NUM_DCREGS; c++)
    begin
      if (en[c])
        m_ctr[c] = m_ctr[c] + 32'd1;
    end
  endtask

  // expected bus read word for the current model state
  function automatic hssl_reg_pkg::word_t model_read(input hssl_reg_pkg::sec_t s,
      input hssl_reg_pkg::idx_t i, input hssl_reg_pkg::status_t st);
    hssl_reg_pkg::word_t w;
    w = hssl_reg_pkg::BAD_REG;
    if (s == hssl_reg_pkg::SEC_IFCAS)
    begin
      case (i)
        hssl_reg_pkg::REG_STOP:      w = {31'd0, m_cfg.stop};
        hssl_reg_pkg::REG_SOFT_RES:  w = '0;
        hssl_reg_pkg::REG_REPLY_KEY: w = m_cfg.reply_key;
        hssl_reg_pkg::REG_IN_WAIT:   w = m_cfg.in_wait;
        hssl_reg_pkg::REG_OUT_WAIT:  w = m_cfg.out_wait;
        hssl_reg_pkg::REG_OUT_TICK:  w = m_cfg.out_tick;
        hssl_reg_pkg::REG_OUT_SIZE:  w = {22'd0, m_cfg.out_size};
        hssl_reg_pkg::REG_STATUS:
        begin
          w         = '0;
          w[31:20]  = hssl_reg_pkg::STATUS_TAG;
          w[5]      = st.hs_mismatch;
          w[4]      = st.hs_complete;
          w[3:0]    = st.sntl;
        end
        hssl_reg_pkg::REG_HW_VER:    w = hssl_reg_pkg::HW_VERSION_WORD;
        default:                     w = hssl_reg_pkg::BAD_REG;
      endcase
    end
    else if (s == hssl_reg_pkg::SEC_RTKEY && i < hssl_reg_pkg::NUM_RTREGS)
      w = m_rt.key[i];
    else if (s == hssl_reg_pkg::SEC_RTMSK && i < hssl_reg_pkg::NUM_RTREGS)
      w = m_rt.mask[i];
    else if (s == hssl_reg_pkg::SEC_RTRTE && i < hssl_reg_pkg::NUM_RTREGS)
      w = {29'd0, m_rt.route[i]};
    else if (s == hssl_reg_pkg::SEC_DCCNT && i < hssl_reg_pkg::NUM_DCREGS)
      w = m_ctr[i];
    return w;
  endfunction

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input string what, input hssl_reg_pkg::word_t got,
                            input hssl_reg_pkg::word_t exp);
    if (got !== exp)
    begin
      err_total++;
      err_test++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cfg(input hssl_reg_pkg::cfg_t got, input hssl_reg_pkg::cfg_t exp);
    if (got !== exp)
    begin
      err_total++;
      err_test++;
      $display("** Error at %0t: cfg is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_rt(input hssl_reg_pkg::rt_tab_t got, input hssl_reg_pkg::rt_tab_t exp);
    if (got !== exp)
    begin
      err_total++;
      err_test++;
      $display("** Error at %0t: rt is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp)
    begin
      err_total++;
      err_test++;
      $display("** Error at %0t: pready is %b, expected %b", $time, got, exp);
    end
  endtask

`endif

// ==== tb_hssl_reg_bank.sv ====
/*
  testbench for the hssl register bank
  random bus and packet traffic, counters and status, checked
  cycle by cycle against a register model
*/
`timescale 1ns/100ps
module tb_hssl_reg_bank;

  localparam int READY_TIMEOUT = 8;

  logic                                clk;
  logic                                resetn;
  hssl_reg_pkg::apb_req_t              apb;
  hssl_reg_pkg::prx_req_t              prx;
  logic [hssl_reg_pkg::NUM_DCREGS-1:0] cnt_en;
  hssl_reg_pkg::status_t               status;
  hssl_reg_pkg::word_t                 prdata;
  logic                                pready;
  hssl_reg_pkg::cfg_t                  cfg;
  hssl_reg_pkg::rt_tab_t               rt;
  hssl_reg_pkg::ctr_arr_t              ctr;
  hssl_reg_pkg::word_t                 lfsr;
  int                                  tests_run;

  `include "tb_hssl_reg_model.svh"

  hssl_reg_bank UUT (
    .clk    (clk),
    .resetn (resetn),
    .apb    (apb),
    .prx    (prx),
    .prdata (prdata),
    .pready (pready),
    .cnt_en (cnt_en),
    .status (status),
    .cfg    (cfg),
    .rt     (rt),
    .ctr    (ctr)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1, stepped once per bit
  function automatic hssl_reg_pkg::word_t rand_bits(input int n);
    hssl_reg_pkg::word_t v;
    logic                fb;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_outputs();
    check_cfg(cfg, m_cfg);
    check_rt(rt, m_rt);
    for (int c = 0; c < hssl_reg_pkg::NUM_DCREGS; c++)
      check_word($sformatf("ctr[%0d]", c), ctr[c], m_ctr[c]);
    check_ready(pready, m_ready);
    check_word("prdata", prdata, m_prdata);
  endtask

  // one clock edge; the model applies grant, read and count rules first
  task automatic step();
    logic                wv;
    hssl_reg_pkg::sec_t  ws;
    hssl_reg_pkg::idx_t  wi;
    hssl_reg_pkg::word_t wd;
    wv = prx.en;
    ws = prx.addr[7:4];
    wi = prx.addr[3:0];
    wd = prx.wdata;
    if (!prx.en)
    begin
      wv = apb.sel && apb.write;
      ws = apb.addr[9:6];
      wi = apb.addr[5:2];
      wd = apb.wdata;
    end
    if (apb.sel && !apb.write)
      m_prdata = model_read(apb.addr[9:6], apb.addr[5:2], status);
    model_count(cnt_en);
    if (wv)
      model_write(ws, wi, wd);
    m_ready = !(apb.sel && prx.en);
    @(posedge clk);
    #1;
    check_outputs();
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (pready !== 1'b1 && n < READY_TIMEOUT)
    begin
      step();
      n++;
    end
    if (pready !== 1'b1)
    begin
      $display("timeout: pready still low after %0d cycles", READY_TIMEOUT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  endtask

  task automatic bus_access(input logic w, input hssl_reg_pkg::sec_t s,
                            input hssl_reg_pkg::idx_t i, input hssl_reg_pkg::word_t d);
    wait_ready();
    apb = '{sel: 1'b1, write: w, addr: {s, i, 2'b00}, wdata: d};
    step();
    apb = '0;
  endtask

  task automatic pkt_write(input hssl_reg_pkg::reg_addr_t a, input hssl_reg_pkg::word_t d);
    prx = '{en: 1'b1, addr: a, wdata: d};
    step();
    prx = '0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s: %s", tests_run, name, (err_test == 0) ? "ok" : "mismatches");
    err_test = 0;
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    hssl_reg_pkg::apb_req_t held;
    hssl_reg_pkg::prx_req_t pkt;
    logic                   collide;
    lfsr      = 32'he773_2ffd;
    tests_run = 0;
    err_total = 0;
    err_test  = 0;
    resetn    = 1'b0;
    apb       = '0;
    prx       = '0;
    cnt_en    = '0;
    status    = '0;
    model_defaults();
    m_ctr     = '0;
    m_prdata  = '0;
    m_ready   = 1'b0;
    repeat (3) @(posedge clk);
    #1 resetn = 1'b1;

    // defaults with pready low then high
    check_outputs();
    step();
    for (int s = 0; s < 6; s++)
      for (int i = 0; i < 16; i++)
        bus_access(1'b0, 4'(s), 4'(i), '0);
    end_test("reset defaults");

    for (int n = 0; n < 60; n++)
    begin
      held = '{sel: 1'b1, write: 1'b1, addr: 10'(rand_bits(9)), wdata: rand_bits(32)};
      bus_access(1'b1, held.addr[9:6], held.addr[5:2], held.wdata);
      bus_access(1'b0, held.addr[9:6], held.addr[5:2], '0);
    end
    end_test("bus write and read back");

    // packet write beats a colliding bus access
    for (int n = 0; n < 40; n++)
    begin
      wait_ready();
      held    = '{sel: 1'b1, write: 1'(rand_bits(1)), addr: 10'(rand_bits(10)),
                  wdata: rand_bits(32)};
      pkt     = '{en: 1'b1, addr: 8'(rand_bits(7)), wdata: rand_bits(32)};
      collide = 1'(rand_bits(1));
      // same register now and then
      if (collide && rand_bits(1) == 32'd1)
        held.addr = {pkt.addr, 2'b00};
      prx = pkt;
      if (collide)
        apb = held;
      step();
      apb = '0;
      prx = '0;
      bus_access(1'b0, pkt.addr[7:4], pkt.addr[3:0], '0);
      if (collide)
      begin
        // stalled bus write left its register alone
        bus_access(1'b0, held.addr[9:6], held.addr[5:2], '0);
        bus_access(held.write, held.addr[9:6], held.addr[5:2], held.wdata);
      end
    end
    end_test("packet priority");

    cnt_en = '1;
    for (int n = 0; n < 8; n++)
      bus_access(1'b1, 4'(rand_bits(2)), 4'(rand_bits(3)), rand_bits(32));
    bus_access(1'b1, hssl_reg_pkg::SEC_IFCAS, hssl_reg_pkg::REG_SOFT_RES, rand_bits(32));
    for (int n = 0; n < 8; n++)
      pkt_write({4'(rand_bits(2)), 4'(rand_bits(3))}, rand_bits(32));
    pkt_write({hssl_reg_pkg::SEC_IFCAS, hssl_reg_pkg::REG_SOFT_RES}, rand_bits(32));
    cnt_en = '0;
    end_test("soft reset");

    for (int n = 0; n < 50; n++)
    begin
      cnt_en = 4'(rand_bits(4));
      if (rand_bits(2) == 32'd0)
      begin
        // load beats counting
        cnt_en = '1;
        pkt_write({hssl_reg_pkg::SEC_DCCNT, 4'(rand_bits(2))}, rand_bits(32));
      end
      else
        bus_access(1'b0, hssl_reg_pkg::SEC_DCCNT, 4'(rand_bits(3)), '0);
    end
    cnt_en = '0;
    end_test("diagnostic counters");

    for (int n = 0; n < 20; n++)
    begin
      status = 6'(rand_bits(6));
      bus_access(1'b0, hssl_reg_pkg::SEC_IFCAS, hssl_reg_pkg::REG_STATUS, '0);
      bus_access(1'b0, hssl_reg_pkg::SEC_IFCAS, hssl_reg_pkg::REG_HW_VER, '0);
    end
    end_test("status and version");

    $display("%0d tests run, %0d errors", tests_run, err_total);
    if (err_total == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== hssl_reg_bank.sv ====
/*
  hssl register bank
  configuration and diagnostic registers of the event-stream link,
  written from the bus and from packets, read back over the bus
*/
`timescale 1ns/100ps
module hssl_reg_bank
(
  input  logic                                clk,
  input  logic                                resetn,

  // bus and packet access
  input  hssl_reg_pkg::apb_req_t              apb,
  input  hssl_reg_pkg::prx_req_t              prx,
  output hssl_reg_pkg::word_t                 prdata,
  output logic                                pready,

  // counter enables and link status
  input  logic [hssl_reg_pkg::NUM_DCREGS-1:0] cnt_en,
  input  hssl_reg_pkg::status_t               status,

  // register contents
  output hssl_reg_pkg::cfg_t                  cfg,
  output hssl_reg_pkg::rt_tab_t               rt,
  output hssl_reg_pkg::ctr_arr_t              ctr
);

  hssl_reg_pkg::wr_req_t wr_req;
  hssl_reg_pkg::rd_req_t rd_req;

  // --------------------------------------------------------------------------
  // access decode and write grant
  // --------------------------------------------------------------------------
  hssl_access_decoder u_decoder (
    .clk    (clk),
    .resetn (resetn),
    .apb    (apb),
    .prx    (prx),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .pready (pready)
  );

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------
  hssl_config_regs u_config (
    .clk    (clk),
    .resetn (resetn),
    .wr_req (wr_req),
    .cfg    (cfg),
    .rt     (rt)
  );

  hssl_diag_counters u_counters (
    .clk    (clk),
    .resetn (resetn),
    .wr_req (wr_req),
    .cnt_en (cnt_en),
    .ctr    (ctr)
  );

  // bus read back
  hssl_read_mux u_read_mux (
    .clk    (clk),
    .resetn (resetn),
    .rd_req (rd_req),
    .cfg    (cfg),
    .rt     (rt),
    .ctr    (ctr),
    .status (status),
    .prdata (prdata)
  );

endmodule

// ==== hssl_read_mux.sv ====
/*
  hssl read multiplexer
  selects the addressed word from every section, status and version
  and registers it as bus read data
*/
`timescale 1ns/100ps
module hssl_read_mux
(
  input  logic                   clk,
  input  logic                   resetn,
  input  hssl_reg_pkg::rd_req_t  rd_req,
  input  hssl_reg_pkg::cfg_t     cfg,
  input  hssl_reg_pkg::rt_tab_t  rt,
  input  hssl_reg_pkg::ctr_arr_t ctr,
  input  hssl_reg_pkg::status_t  status,
  output hssl_reg_pkg::word_t    prdata
);

  hssl_reg_pkg::word_t rd_word;
  hssl_reg_pkg::word_t status_word;
  logic                rt_in_range;
  logic                dc_in_range;

  // tag, then handshake flags and sentinel in the low bits
  assign status_word = {hssl_reg_pkg::STATUS_TAG, 14'd0,
                        status.hs_mismatch, status.hs_complete, status.sntl};

  assign rt_in_range = rd_req.idx < hssl_reg_pkg::NUM_RTREGS;
  assign dc_in_range = rd_req.idx < hssl_reg_pkg::NUM_DCREGS;

  // --------------------------------------------------------------------------
  // word select
  // --------------------------------------------------------------------------
  always_comb
  begin
    rd_word = hssl_reg_pkg::BAD_REG;
    case (rd_req.sec)
      hssl_reg_pkg::SEC_IFCAS:
        case (rd_req.idx)
          hssl_reg_pkg::REG_STOP:      rd_word = hssl_reg_pkg::word_t'(cfg.stop);
          hssl_reg_pkg::REG_SOFT_RES:  rd_word = '0;
          hssl_reg_pkg::REG_REPLY_KEY: rd_word = cfg.reply_key;
          hssl_reg_pkg::REG_IN_WAIT:   rd_word = cfg.in_wait;
          hssl_reg_pkg::REG_OUT_WAIT:  rd_word = cfg.out_wait;
          hssl_reg_pkg::REG_OUT_TICK:  rd_word = cfg.out_tick;
          hssl_reg_pkg::REG_OUT_SIZE:  rd_word = hssl_reg_pkg::word_t'(cfg.out_size);
          hssl_reg_pkg::REG_STATUS:    rd_word = status_word;
          hssl_reg_pkg::REG_HW_VER:    rd_word = hssl_reg_pkg::HW_VERSION_WORD;
          default:                     rd_word = hssl_reg_pkg::BAD_REG;
        endcase
      hssl_reg_pkg::SEC_RTKEY:
        if (rt_in_range)
          rd_word = rt.key[rd_req.idx];
      hssl_reg_pkg::SEC_RTMSK:
        if (rt_in_range)
          rd_word = rt.mask[rd_req.idx];
      hssl_reg_pkg::SEC_RTRTE:
        if (rt_in_range)
          rd_word = hssl_reg_pkg::word_t'(rt.route[rd_req.idx]);
      hssl_reg_pkg::SEC_DCCNT:
        if (dc_in_range)
          rd_word = ctr[rd_req.idx];
      default:
        rd_word = hssl_reg_pkg::BAD_REG;
    endcase
  end

  // read data holds until the next read
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      prdata <= '0;
    else if (rd_req.valid)
      prdata <= rd_word;
  end

endmodule

// ==== hssl_diag_counters.sv ====
/*
  hssl diagnostic counters
  free-running event counters, loadable by a granted write which
  takes priority over counting
*/
`timescale 1ns/100ps
module hssl_diag_counters
(
  input  logic                                clk,
  input  logic                                resetn,
  input  hssl_reg_pkg::wr_req_t               wr_req,
  input  logic [hssl_reg_pkg::NUM_DCREGS-1:0] cnt_en,
  output hssl_reg_pkg::ctr_arr_t              ctr
);

  logic                                dc_hit;
  logic [hssl_reg_pkg::NUM_DCREGS-1:0] ctr_wr;

  assign dc_hit = wr_req.valid && (wr_req.sec == hssl_reg_pkg::SEC_DCCNT);

  // one-hot load select per counter
  always_comb
  begin
    for (int i = 0; i < hssl_reg_pkg::NUM_DCREGS; i++)
      ctr_wr[i] = dc_hit && (wr_req.idx == hssl_reg_pkg::idx_t'(i));
  end

  // counters wrap at 2^32
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      ctr <= '0;
    end
    else
    begin
      for (int i = 0; i < hssl_reg_pkg::NUM_DCREGS; i++)
      begin
        if (ctr_wr[i])
          ctr[i] <= wr_req.data;
        else if (cnt_en[i])
          ctr[i] <= ctr[i] + hssl_reg_pkg::word_t'(1);
      end
    end
  end

endmodule

// ==== hssl_config_regs.sv ====
/*
  hssl configuration registers
  interface control words and input router tables, loaded with their
  defaults on reset and on soft reset
*/
`timescale 1ns/100ps
module hssl_config_regs
(
  input  logic                   clk,
  input  logic                   resetn,
  input  hssl_reg_pkg::wr_req_t  wr_req,
  output hssl_reg_pkg::cfg_t     cfg,
  output hssl_reg_pkg::rt_tab_t  rt
);

  logic ifc_wr;
  logic rt_wr;

  assign ifc_wr = wr_req.valid && (wr_req.sec == hssl_reg_pkg::SEC_IFCAS);

  // router sections share the index range
  assign rt_wr  = wr_req.valid && (wr_req.idx < hssl_reg_pkg::NUM_RTREGS);

  // --------------------------------------------------------------------------
  // interface control
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      cfg <= hssl_reg_pkg::CFG_DEF;
    end
    else if (wr_req.soft_reset)
    begin
      cfg <= hssl_reg_pkg::CFG_DEF;
    end
    else if (ifc_wr)
    begin
      case (wr_req.idx)
        hssl_reg_pkg::REG_STOP:
          cfg.stop <= wr_req.data[0];
        hssl_reg_pkg::REG_REPLY_KEY:
          cfg.reply_key <= wr_req.data;
        hssl_reg_pkg::REG_IN_WAIT:
          cfg.in_wait <= wr_req.data;
        hssl_reg_pkg::REG_OUT_WAIT:
          cfg.out_wait <= wr_req.data;
        hssl_reg_pkg::REG_OUT_TICK:
          cfg.out_tick <= wr_req.data;
        hssl_reg_pkg::REG_OUT_SIZE:
          cfg.out_size <= hssl_reg_pkg::size_t'(wr_req.data);
        // status, version and unused indices hold
        default:
          cfg <= cfg;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // input router tables
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      rt <= hssl_reg_pkg::RT_TAB_DEF;
    end
    else if (wr_req.soft_reset)
    begin
      rt <= hssl_reg_pkg::RT_TAB_DEF;
    end
    else if (rt_wr)
    begin
      case (wr_req.sec)
        hssl_reg_pkg::SEC_RTKEY:
          rt.key[wr_req.idx] <= wr_req.data;
        hssl_reg_pkg::SEC_RTMSK:
          rt.mask[wr_req.idx] <= wr_req.data;
        // only the low route bits are kept
        hssl_reg_pkg::SEC_RTRTE:
          rt.route[wr_req.idx] <= hssl_reg_pkg::route_t'(wr_req.data);
        default:
          rt <= rt;
      endcase
    end
  end

endmodule

// ==== hssl_access_decoder.sv ====
/*
  hssl access decoder
  splits bus and packet addresses, grants one write per cycle with the
  packet port first, flags soft reset and stalls the bus on a collision
*/
`timescale 1ns/100ps
module hssl_access_decoder
(
  input  logic                   clk,
  input  logic                   resetn,
  input  hssl_reg_pkg::apb_req_t apb,
  input  hssl_reg_pkg::prx_req_t prx,
  output hssl_reg_pkg::wr_req_t  wr_req,
  output hssl_reg_pkg::rd_req_t  rd_req,
  output logic                   pready
);

  // bus addresses are byte addresses
  hssl_reg_pkg::reg_addr_t apb_word;
  hssl_reg_pkg::sec_t      apb_sec;
  hssl_reg_pkg::idx_t      apb_idx;
  hssl_reg_pkg::sec_t      prx_sec;
  hssl_reg_pkg::idx_t      prx_idx;
  logic                    apb_wr;

  assign apb_word = apb.addr[9:2];
  assign apb_sec  = apb_word[7:4];
  assign apb_idx  = apb_word[3:0];
  assign prx_sec  = prx.addr[7:4];
  assign prx_idx  = prx.addr[3:0];
  assign apb_wr   = apb.sel && apb.write;

  // --------------------------------------------------------------------------
  // write grant
  // --------------------------------------------------------------------------
  always_comb
  begin
    wr_req = '0;
    if (prx.en)
    begin
      wr_req.valid = 1'b1;
      wr_req.sec   = prx_sec;
      wr_req.idx   = prx_idx;
      wr_req.data  = prx.wdata;
    end
    else if (apb_wr)
    begin
      wr_req.valid = 1'b1;
      wr_req.sec   = apb_sec;
      wr_req.idx   = apb_idx;
      wr_req.data  = apb.wdata;
    end
    // soft reset register has no storage
    wr_req.soft_reset = wr_req.valid
                        && (wr_req.sec == hssl_reg_pkg::SEC_IFCAS)
                        && (wr_req.idx == hssl_reg_pkg::REG_SOFT_RES);
  end

  assign rd_req = '{valid: apb.sel && !apb.write, sec: apb_sec, idx: apb_idx};

  // one-cycle stall whenever a packet write meets a bus access
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      pready <= 1'b0;
    else
      pready <= !(apb.sel && prx.en);
  end

endmodule

// ==== hssl_reg_pkg.sv ====
/*
  hssl register bank package
  widths, section and register codes, default words and the structs
  shared by the configuration and diagnostic register blocks
*/
package hssl_reg_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  typedef logic [31:0] word_t;
  // word address, section in [7:4], register index in [3:0]
  typedef logic [7:0]  reg_addr_t;
  // byte address as seen on the bus
  typedef logic [9:0]  apb_addr_t;
  typedef logic [3:0]  sec_t;
  typedef logic [3:0]  idx_t;
  typedef logic [2:0]  route_t;
  typedef logic [9:0]  size_t;
  typedef logic [3:0]  sntl_t;

  // registers per section
  localparam int NUM_IFREGS = 7;
  localparam int NUM_RTREGS = 4;
  localparam int NUM_DCREGS = 4;

  // --------------------------------------------------------------------------
  // section codes and register indices
  // --------------------------------------------------------------------------
  // interface control and status
  localparam sec_t SEC_IFCAS = 4'd0;
  // input router keys, masks and routes
  localparam sec_t SEC_RTKEY = 4'd1;
  localparam sec_t SEC_RTMSK = 4'd2;
  localparam sec_t SEC_RTRTE = 4'd3;
  // diagnostic counters
  localparam sec_t SEC_DCCNT = 4'd4;

  localparam idx_t REG_STOP      = 4'd0;
  localparam idx_t REG_SOFT_RES  = 4'd1;
  localparam idx_t REG_REPLY_KEY = 4'd2;
  localparam idx_t REG_IN_WAIT   = 4'd3;
  localparam idx_t REG_OUT_WAIT  = 4'd4;
  localparam idx_t REG_OUT_TICK  = 4'd5;
  localparam idx_t REG_OUT_SIZE  = 4'd6;
  // collected signals, not storage
  localparam idx_t REG_STATUS    = 4'd14;
  localparam idx_t REG_HW_VER    = 4'd15;

  // --------------------------------------------------------------------------
  // default and fixed words
  // --------------------------------------------------------------------------
  localparam word_t STOP_DEF      = 32'd0;
  // remote reply routing key
  localparam word_t REPLY_KEY_DEF = 32'hffff_fd00;
  localparam word_t IN_WAIT_DEF   = 32'd32;
  localparam word_t OUT_WAIT_DEF  = 32'd0;
  localparam word_t OUT_TICK_DEF  = 32'd1000;
  localparam word_t OUT_SIZE_DEF  = 32'd256;
  // all-ones key forces a router miss
  localparam word_t RT_KEY_DEF    = 32'hffff_ffff;
  localparam word_t RT_MSK_DEF    = 32'h0000_0000;
  localparam word_t RT_RTE_DEF    = 32'h0000_0000;

  localparam word_t       BAD_REG         = 32'hdead_beef;
  localparam logic [11:0] STATUS_TAG      = 12'h5ec;
  localparam word_t       HW_VERSION_WORD = 32'h0001_0100;

  // --------------------------------------------------------------------------
  // structs
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic      sel;
    logic      write;
    apb_addr_t addr;
    word_t     wdata;
  } apb_req_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     wdata;
  } prx_req_t;

  // the one granted write of a cycle
  typedef struct packed {
    logic  valid;
    logic  soft_reset;
    sec_t  sec;
    idx_t  idx;
    word_t data;
  } wr_req_t;

  typedef struct packed {
    logic valid;
    sec_t sec;
    idx_t idx;
  } rd_req_t;

  typedef struct packed {
    logic  stop;
    word_t reply_key;
    word_t in_wait;
    word_t out_wait;
    word_t out_tick;
    size_t out_size;
  } cfg_t;

  typedef struct packed {
    word_t  [NUM_RTREGS-1:0] key;
    word_t  [NUM_RTREGS-1:0] mask;
    route_t [NUM_RTREGS-1:0] route;
  } rt_tab_t;

  typedef struct packed {
    logic  hs_mismatch;
    logic  hs_complete;
    sntl_t sntl;
  } status_t;

  typedef word_t [NUM_DCREGS-1:0] ctr_arr_t;

  // register contents after reset or soft reset
  localparam cfg_t CFG_DEF = '{
    stop:      STOP_DEF[0],
    reply_key: REPLY_KEY_DEF,
    in_wait:   IN_WAIT_DEF,
    out_wait:  OUT_WAIT_DEF,
    out_tick:  OUT_TICK_DEF,
    out_size:  size_t'(OUT_SIZE_DEF)
  };

  localparam rt_tab_t RT_TAB_DEF = '{
    key:   {NUM_RTREGS{RT_KEY_DEF}},
    mask:  {NUM_RTREGS{RT_MSK_DEF}},
    route: {NUM_RTREGS{route_t'(RT_RTE_DEF)}}
  };

endpackage
